//--- sources.f
+incdir+hw
hw/mem_pkg.sv
hw/sram_bank.sv
hw/mem_arbiter.sv
hw/mem_subsys_top.sv
tests/tb_clk_gen.sv
tests/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_top -f sources.f -o tb_top_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module tb_top;

  localparam int unsigned N_WORDS     = 16;
  localparam int unsigned TOTAL_REQS  = 2 + 32 + 32 + 24 + 64 + 12;
  localparam int unsigned CYCLE_LIMIT = TOTAL_REQS * 4 + `TB_TIMEOUT_MARGIN;

  logic           clk;
  logic           reset;
  logic           instr_req;
  mem_pkg::addr_t instr_addr;
  logic           instr_gnt;
  logic           instr_rvalid;
  mem_pkg::data_t instr_rdata;
  logic           instr_err;
  logic           data_req;
  mem_pkg::addr_t data_addr;
  logic           data_we;
  mem_pkg::be_t   data_be;
  mem_pkg::data_t data_wdata;
  logic           data_gnt;
  logic           data_rvalid;
  mem_pkg::data_t data_rdata;
  logic           data_err;

  integer             seed;
  int unsigned        cycle_cnt = 0;
  string              cur_test;
  int unsigned        test_errs;
  int unsigned        test_checks;
  int unsigned        total_errs = 0;
  int unsigned        total_checks = 0;
  int unsigned        tests_passed = 0;
  int unsigned        tests_failed = 0;
  logic               allow_idle;
  logic               i_hold;
  logic               d_hold;
  mem_pkg::arb_prio_e model_prio;

  // reference image of the sram
  mem_pkg::data_t model_mem [`MEM_WORDS];
  mem_pkg::addr_t wr_addr [N_WORDS];

  // requests waiting to be presented
  mem_pkg::addr_t i_req_addr [$];
  mem_pkg::addr_t d_req_addr [$];
  logic           d_req_we [$];
  mem_pkg::be_t   d_req_be [$];
  mem_pkg::data_t d_req_wdata [$];

  // expected responses, in acceptance order
  mem_pkg::data_t i_exp_data [$];
  logic           i_exp_err [$];
  int unsigned    i_exp_cycle [$];
  mem_pkg::data_t d_exp_data [$];
  logic           d_exp_err [$];
  int unsigned    d_exp_cycle [$];

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .reset_o (reset)
  );

  mem_subsys_top dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .instr_err_o    (instr_err),
    .data_req_i     (data_req),
    .data_addr_i    (data_addr),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_wdata_i   (data_wdata),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata),
    .data_err_o     (data_err)
  );

  always @(negedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles in test %s", CYCLE_LIMIT, cur_test);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    test_checks++;
    assert (act === exp) else begin
      test_errs++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    test_checks++;
    assert (cond === 1'b1) else begin
      test_errs++;
      $display("error in %s: %s", cur_test, msg);
    end
  endtask

  task automatic queue_fetch(input mem_pkg::addr_t addr);
    i_req_addr.push_back(addr);
  endtask

  task automatic queue_data(input mem_pkg::addr_t addr, input logic we,
                            input mem_pkg::be_t be, input mem_pkg::data_t wdata);
    d_req_addr.push_back(addr);
    d_req_we.push_back(we);
    d_req_be.push_back(be);
    d_req_wdata.push_back(wdata);
  endtask

  // model update at the accepting edge
  task automatic accept_fetch(input mem_pkg::addr_t addr);
    if (addr >= mem_pkg::addr_t'(4 * `MEM_WORDS)) begin
      i_exp_data.push_back('0);
      i_exp_err.push_back(1'b1);
    end else begin
      i_exp_data.push_back(model_mem[mem_pkg::word_idx_t'(addr >> 2)]);
      i_exp_err.push_back(1'b0);
    end
    i_exp_cycle.push_back(cycle_cnt + `MEM_LATENCY);
  endtask

  task automatic accept_data(input mem_pkg::addr_t addr, input logic we,
                             input mem_pkg::be_t be, input mem_pkg::data_t wdata);
    mem_pkg::word_idx_t idx;
    mem_pkg::data_t     merged;
    idx = mem_pkg::word_idx_t'(addr >> 2);
    if (addr >= mem_pkg::addr_t'(4 * `MEM_WORDS)) begin
      d_exp_data.push_back('0);
      d_exp_err.push_back(1'b1);
    end else if (we) begin
      merged = model_mem[idx];
      for (int b = 0; b < 4; b++) begin
        if (be[b]) merged[8*b +: 8] = wdata[8*b +: 8];
      end
      model_mem[idx] = merged;
      d_exp_data.push_back('0);
      d_exp_err.push_back(1'b0);
    end else begin
      d_exp_data.push_back(model_mem[idx]);
      d_exp_err.push_back(1'b0);
    end
    d_exp_cycle.push_back(cycle_cnt + `MEM_LATENCY);
  endtask

  // one clock: drive at the falling edge, then check once things settle
  task automatic step();
    logic [31:0] rnd;
    @(negedge clk);
    rnd = $random(seed);
    if (!i_hold) begin
      instr_req = 1'b0;
      if (i_req_addr.size() != 0 && (!allow_idle || rnd[1:0] != 2'b00)) begin
        instr_req  = 1'b1;
        instr_addr = i_req_addr[0];
        i_hold     = 1'b1;
      end
    end
    if (!d_hold) begin
      data_req = 1'b0;
      if (d_req_addr.size() != 0 && (!allow_idle || rnd[3:2] != 2'b00)) begin
        data_req   = 1'b1;
        data_addr  = d_req_addr[0];
        data_we    = d_req_we[0];
        data_be    = d_req_be[0];
        data_wdata = d_req_wdata[0];
        d_hold     = 1'b1;
      end
    end
    #1;
    if (instr_rvalid) begin
      expect_true(i_exp_data.size() != 0, "fetch response with nothing outstanding");
      if (i_exp_data.size() != 0) begin
        compare_value("fetch rdata", i_exp_data.pop_front(), instr_rdata);
        compare_value("fetch err", {31'b0, i_exp_err.pop_front()}, {31'b0, instr_err});
        compare_value("fetch response cycle", i_exp_cycle.pop_front(), cycle_cnt);
      end
    end
    if (data_rvalid) begin
      expect_true(d_exp_data.size() != 0, "data response with nothing outstanding");
      if (d_exp_data.size() != 0) begin
        compare_value("data rdata", d_exp_data.pop_front(), data_rdata);
        compare_value("data err", {31'b0, d_exp_err.pop_front()}, {31'b0, data_err});
        compare_value("data response cycle", d_exp_cycle.pop_front(), cycle_cnt);
      end
    end
    if (reset) begin
      expect_true(!instr_gnt && !data_gnt && !instr_rvalid && !data_rvalid,
                  "grant or response valid high during reset");
      model_prio = mem_pkg::PRIO_FETCH;
    end else begin
      expect_true(!(instr_gnt && data_gnt), "both grants high in the same cycle");
      if (instr_req && data_req) begin
        compare_value("contended winner is data", {31'b0, model_prio == mem_pkg::PRIO_DATA},
                      {31'b0, data_gnt});
      end
      if (instr_req || data_req) begin
        expect_true(instr_gnt || data_gnt, "pending request left without a grant");
      end
      if (instr_gnt) begin
        model_prio = mem_pkg::PRIO_DATA;
        accept_fetch(instr_addr);
        void'(i_req_addr.pop_front());
        i_hold = 1'b0;
      end else if (data_gnt) begin
        model_prio = mem_pkg::PRIO_FETCH;
        accept_data(data_addr, data_we, data_be, data_wdata);
        void'(d_req_addr.pop_front());
        void'(d_req_we.pop_front());
        void'(d_req_be.pop_front());
        void'(d_req_wdata.pop_front());
        d_hold = 1'b0;
      end
    end
  endtask

  task automatic drain();
    while (i_req_addr.size() != 0 || d_req_addr.size() != 0 ||
           i_exp_data.size() != 0 || d_exp_data.size() != 0) begin
      step();
    end
  endtask

  task automatic begin_test(input string name, input logic idle);
    cur_test    = name;
    test_errs   = 0;
    test_checks = 0;
    allow_idle  = idle;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: ok, %0d checks", cur_test, test_checks);
    end else begin
      tests_failed++;
      $display("test %s: failed, %0d of %0d checks wrong", cur_test, test_errs, test_checks);
    end
    total_errs   += test_errs;
    total_checks += test_checks;
  endtask

  initial begin
    logic [31:0] rnd;
    seed       = 32'h7f3b_eaf0;
    instr_req  = 1'b0;
    instr_addr = '0;
    data_req   = 1'b0;
    data_addr  = '0;
    data_we    = 1'b0;
    data_be    = '0;
    data_wdata = '0;
    i_hold     = 1'b0;
    d_hold     = 1'b0;
    model_prio = mem_pkg::PRIO_FETCH;

    // out of range on both ports, so the data is defined right after reset
    begin_test("reset_state", 1'b0);
    do begin
      step();
    end while (reset);
    queue_fetch(32'h0000_2000);
    queue_data(32'h0000_3004, 1'b0, 4'hf, '0);
    drain();
    end_test();

    begin_test("write_read", 1'b1);
    for (int i = 0; i < N_WORDS; i++) begin
      rnd = $random(seed);
      wr_addr[i] = (rnd % mem_pkg::addr_t'(4 * `MEM_WORDS)) & 32'hffff_fffc;
      queue_data(wr_addr[i], 1'b1, 4'hf, $random(seed));
    end
    for (int i = 0; i < N_WORDS; i++) queue_data(wr_addr[i], 1'b0, 4'hf, '0);
    drain();
    end_test();

    begin_test("byte_enable", 1'b1);
    for (int i = 0; i < N_WORDS; i++) begin
      rnd = $random(seed);
      queue_data(wr_addr[i], 1'b1, rnd[3:0], $random(seed));
    end
    for (int i = 0; i < N_WORDS; i++) queue_data(wr_addr[i], 1'b0, 4'hf, '0);
    drain();
    end_test();

    begin_test("fetch_read", 1'b1);
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      queue_fetch(wr_addr[rnd[3:0]]);
    end
    drain();
    end_test();

    // both ports stay busy, so grants must alternate every cycle
    begin_test("contention", 1'b0);
    for (int i = 0; i < 32; i++) begin
      rnd = $random(seed);
      queue_fetch(wr_addr[rnd[3:0]]);
      queue_data(wr_addr[rnd[7:4]], rnd[8], 4'hf, $random(seed));
    end
    drain();
    end_test();

    // upper address bits set, low bits alias words that hold known data
    begin_test("out_of_range", 1'b1);
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      queue_data(wr_addr[i] + ({rnd[19:0], 12'h000} | 32'h1000), 1'b1, 4'hf, $random(seed));
    end
    for (int i = 0; i < 2; i++) begin
      rnd = $random(seed);
      queue_data(wr_addr[i] + ({rnd[19:0], 12'h000} | 32'h1000), 1'b0, 4'hf, '0);
      queue_fetch(wr_addr[i + 2] + ({rnd[31:12], 12'h000} | 32'h1000));
    end
    for (int i = 0; i < 4; i++) queue_data(wr_addr[i], 1'b0, 4'hf, '0);
    drain();
    end_test();

    $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
             tests_passed, tests_failed, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 20,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a falling edge, after the reset rising edges
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- hw/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  logic            clk_i,
  input  logic            reset_i,

  // instruction fetch
  input  logic            instr_req_i,
  input  mem_pkg::addr_t  instr_addr_i,
  output logic            instr_gnt_o,
  output logic            instr_rvalid_o,
  output mem_pkg::data_t  instr_rdata_o,
  output logic            instr_err_o,

  // load/store
  input  logic            data_req_i,
  input  mem_pkg::addr_t  data_addr_i,
  input  logic            data_we_i,
  input  mem_pkg::be_t    data_be_i,
  input  mem_pkg::data_t  data_wdata_i,
  output logic            data_gnt_o,
  output logic            data_rvalid_o,
  output mem_pkg::data_t  data_rdata_o,
  output logic            data_err_o
);

  // shared access path into the sram
  logic           mem_valid;
  logic           mem_we;
  mem_pkg::be_t   mem_be;
  mem_pkg::addr_t mem_addr;
  mem_pkg::data_t mem_wdata;
  logic           mem_rvalid;
  mem_pkg::data_t mem_rdata;
  logic           mem_err;

  mem_arbiter u_arbiter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .instr_err_o    (instr_err_o),
    .data_req_i     (data_req_i),
    .data_addr_i    (data_addr_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_wdata_i   (data_wdata_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .data_err_o     (data_err_o),
    .mem_valid_o    (mem_valid),
    .mem_we_o       (mem_we),
    .mem_be_o       (mem_be),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_rvalid_i   (mem_rvalid),
    .mem_rdata_i    (mem_rdata),
    .mem_err_i      (mem_err)
  );

  sram_bank u_sram (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_valid_i  (mem_valid),
    .mem_we_i     (mem_we),
    .mem_be_i     (mem_be),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata),
    .mem_err_o    (mem_err)
  );

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_arbiter (
  input  logic            clk_i,
  input  logic            reset_i,

  // fetch port
  input  logic            instr_req_i,
  input  mem_pkg::addr_t  instr_addr_i,
  output logic            instr_gnt_o,
  output logic            instr_rvalid_o,
  output mem_pkg::data_t  instr_rdata_o,
  output logic            instr_err_o,

  // load/store port
  input  logic            data_req_i,
  input  mem_pkg::addr_t  data_addr_i,
  input  logic            data_we_i,
  input  mem_pkg::be_t    data_be_i,
  input  mem_pkg::data_t  data_wdata_i,
  output logic            data_gnt_o,
  output logic            data_rvalid_o,
  output mem_pkg::data_t  data_rdata_o,
  output logic            data_err_o,

  // toward the sram
  output logic            mem_valid_o,
  output logic            mem_we_o,
  output mem_pkg::be_t    mem_be_o,
  output mem_pkg::addr_t  mem_addr_o,
  output mem_pkg::data_t  mem_wdata_o,
  input  logic            mem_rvalid_i,
  input  mem_pkg::data_t  mem_rdata_i,
  input  logic            mem_err_i
);

  localparam int unsigned LAST = `MEM_LATENCY - 1;

  mem_pkg::arb_prio_e prio_q;
  mem_pkg::arb_prio_e prio_d;

  mem_pkg::owner_t grant_owner;

  // owner tags travel alongside the sram pipeline
  logic            tag_valid_q [`MEM_LATENCY];
  mem_pkg::owner_t tag_owner_q [`MEM_LATENCY];

  mem_pkg::owner_t rsp_owner;
  logic            rsp_live;

  // a lone request wins at once, a tie goes to the priority holder
  assign instr_gnt_o = instr_req_i && (!data_req_i || (prio_q == mem_pkg::PRIO_FETCH));
  assign data_gnt_o  = data_req_i && (!instr_req_i || (prio_q == mem_pkg::PRIO_DATA));

  assign grant_owner = data_gnt_o ? mem_pkg::OWNER_DATA : mem_pkg::OWNER_FETCH;

  // the fetch port only reads, so it gets full lanes and no write
  always_comb begin
    mem_valid_o = instr_gnt_o || data_gnt_o;
    if (data_gnt_o) begin
      mem_we_o    = data_we_i;
      mem_be_o    = data_be_i;
      mem_addr_o  = data_addr_i;
      mem_wdata_o = data_wdata_i;
    end else begin
      mem_we_o    = 1'b0;
      mem_be_o    = 4'hf;
      mem_addr_o  = instr_addr_i;
      mem_wdata_o = '0;
    end
  end

  // the winner hands priority to the other port
  always_comb begin
    prio_d = prio_q;
    if (instr_gnt_o) begin
      prio_d = mem_pkg::PRIO_DATA;
    end else if (data_gnt_o) begin
      prio_d = mem_pkg::PRIO_FETCH;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= mem_pkg::PRIO_FETCH;
    end else begin
      prio_q <= prio_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MEM_LATENCY; i++) begin
        tag_valid_q[i] <= 1'b0;
      end
    end else begin
      tag_valid_q[0] <= mem_valid_o;
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        tag_valid_q[i] <= tag_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    tag_owner_q[0] <= grant_owner;
    for (int i = 1; i < `MEM_LATENCY; i++) begin
      tag_owner_q[i] <= tag_owner_q[i-1];
    end
  end

  // steer the response by the tag leaving the pipe
  assign rsp_owner = tag_owner_q[LAST];
  assign rsp_live  = mem_rvalid_i && tag_valid_q[LAST];

  assign instr_rvalid_o = rsp_live && (rsp_owner == mem_pkg::OWNER_FETCH);
  assign data_rvalid_o  = rsp_live && (rsp_owner == mem_pkg::OWNER_DATA);

  assign instr_rdata_o = instr_rvalid_o ? mem_rdata_i : '0;
  assign data_rdata_o  = data_rvalid_o ? mem_rdata_i : '0;
  assign instr_err_o   = instr_rvalid_o && mem_err_i;
  assign data_err_o    = data_rvalid_o && mem_err_i;

  // one port per cycle into the sram
  a_gnt_onehot: assert property (
    @(posedge clk_i) disable iff (reset_i) !(instr_gnt_o && data_gnt_o)
  );

  // every sram response lines up with a tag pushed at grant time
  a_rsp_tagged: assert property (
    @(posedge clk_i) disable iff (reset_i) mem_rvalid_i |-> tag_valid_q[LAST]
  );

endmodule

`default_nettype wire

//--- hw/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module sram_bank (
  input  logic            clk_i,
  input  logic            reset_i,

  input  logic            mem_valid_i,
  input  logic            mem_we_i,
  input  mem_pkg::be_t    mem_be_i,
  input  mem_pkg::addr_t  mem_addr_i,
  input  mem_pkg::data_t  mem_wdata_i,

  output logic            mem_rvalid_o,
  output mem_pkg::data_t  mem_rdata_o,
  output logic            mem_err_o
);

  localparam int unsigned LAST = `MEM_LATENCY - 1;

  // storage, no reset on contents
  mem_pkg::data_t mem_q [`MEM_WORDS];

  mem_pkg::word_idx_t word_idx;
  logic               in_range;
  logic               do_write;
  logic               do_read;

  // read pipeline, one slot per latency cycle
  logic           valid_q [`MEM_LATENCY];
  mem_pkg::data_t rdata_q [`MEM_LATENCY];
  logic           err_q   [`MEM_LATENCY];

  assign in_range = mem_addr_i < mem_pkg::addr_t'(4 * `MEM_WORDS);
  assign word_idx = mem_pkg::word_idx_t'(mem_addr_i >> 2);

  // out of range accesses are dropped
  assign do_write = mem_valid_i && mem_we_i && in_range;
  assign do_read  = mem_valid_i && !mem_we_i && in_range;

  // byte lanes
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_be_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= mem_wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MEM_LATENCY; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= mem_valid_i;
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // writes and errors answer with zero data
  always_ff @(posedge clk_i) begin
    rdata_q[0] <= do_read ? mem_q[word_idx] : '0;
    err_q[0]   <= mem_valid_i && !in_range;
    for (int i = 1; i < `MEM_LATENCY; i++) begin
      rdata_q[i] <= rdata_q[i-1];
      err_q[i]   <= err_q[i-1];
    end
  end

  assign mem_rvalid_o = valid_q[LAST];
  assign mem_rdata_o  = rdata_q[LAST];
  assign mem_err_o    = valid_q[LAST] && err_q[LAST];

  // the arbiter must hand over a known address for every write
  a_wr_addr_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
      (mem_valid_i && mem_we_i) |-> !$isunknown(mem_addr_i)
  );

endmodule

`default_nettype wire

//--- hw/mem_pkg.sv
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

  // byte address as seen on both requester ports
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // word index into the sram array
  typedef logic [$clog2(`MEM_WORDS)-1:0] word_idx_t;

  // requester tag, 0 is fetch and 1 is data
  typedef logic owner_t;

  localparam owner_t OWNER_FETCH = 1'b0;
  localparam owner_t OWNER_DATA  = 1'b1;

  // round-robin priority
  typedef enum logic {
    PRIO_FETCH = 1'b0,
    PRIO_DATA  = 1'b1
  } arb_prio_e;

endpackage

`default_nettype wire

//--- hw/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// number of 32-bit words in the sram
`define MEM_WORDS 1024

// cycles from the granting edge to response valid
`define MEM_LATENCY 2

// extra cycles on top of the computed test length
`define TB_TIMEOUT_MARGIN 200

`endif
